// File: sources.f
rtl/pool_pkg.sv
rtl/pool_csr_pkg.sv
rtl/pool_row_if.sv
rtl/pool_lane_if.sv
rtl/pool_csr.sv
rtl/row_dispatch.sv
rtl/pool_lane.sv
rtl/row_collect.sv
rtl/pool_top.sv
tests/tb_clock.sv
tests/tb_pool_top.sv

// File: run.sh
#!/bin/sh
# Builds the pooling stage testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pool_top \
    -f sources.f \
    --Mdir obj_dir -o sim_pool
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_pool 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test OK"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

// File: tests/tb_pool_top.sv
`timescale 1ns/1ps

module tb_pool_top
    import pool_pkg::*;
    import pool_csr_pkg::*;
();

    localparam int DESIGN_SIZE = 16;
    localparam int ROW_W = DESIGN_SIZE * DWIDTH;
    localparam int WB_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 50;
    localparam int DONE_TIMEOUT = 20;
    localparam int RESET_TIMEOUT = 100;
    localparam logic [ROW_W-1:0] ALT_ROW = {(DESIGN_SIZE / 2){16'h00FF}};

    logic             clk;
    logic             rst;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [7:0]       wb_adr;
    logic [31:0]      wb_dat_w;
    logic [31:0]      wb_dat_r;
    logic             wb_ack;
    logic             in_valid;
    logic [ROW_W-1:0] in_data;
    logic             out_valid;
    logic [ROW_W-1:0] out_data;
    logic             done;

    logic [ROW_W-1:0] exp_q [$];
    logic [ROW_W-1:0] exp_row;
    logic [2:0]       model_win;
    int               cfg_rows;
    int               pass_cnt;
    logic             pass_armed;
    logic             exp_done;
    logic             wb_req;
    logic             wb_req_d;
    logic             wb_ack_d;
    logic [2:0]       in_valid_hist;
    logic [31:0]      rd_data;
    int               seed;
    int               rows_sent;
    int               rows_checked;

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(16)) u_clock (.clk, .rst);

    pool_top #(.DESIGN_SIZE(DESIGN_SIZE)) dut (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .in_valid, .in_data, .out_valid, .out_data, .done
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Average groups of win elements, compact them low and zero the rest.
    function automatic logic [ROW_W-1:0] pool_ref(input logic [ROW_W-1:0] row, input int win);
        logic [ROW_W-1:0] res;
        int               sum;
        res = '0;
        for (int k = 0; k < DESIGN_SIZE / win; k++) begin
            sum = 0;
            for (int j = 0; j < win; j++) begin
                sum = sum + int'(row[(k * win + j) * DWIDTH +: DWIDTH]);
            end
            res[k * DWIDTH +: DWIDTH] = DWIDTH'(sum / win);
        end
        return res;
    endfunction

    function automatic logic [2:0] legal_win(input logic [2:0] code);
        return (code == 3'd2 || code == 3'd4) ? code : 3'd1;
    endfunction

    function automatic logic [ROW_W-1:0] random_row();
        logic [ROW_W-1:0] row;
        for (int i = 0; i < ROW_W / 32; i++) begin
            row[i * 32 +: 32] = $random(seed);
        end
        return row;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            wb_req_d      <= 1'b0;
            wb_ack_d      <= 1'b0;
            in_valid_hist <= '0;
        end else begin
            wb_req_d      <= wb_req;
            wb_ack_d      <= wb_ack;
            in_valid_hist <= {in_valid_hist[1:0], in_valid};
        end
    end

    // Expected rows follow the window the DUT holds when each row is taken.
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            model_win  <= 3'd1;
            cfg_rows   <= 0;
            pass_cnt   <= 0;
            pass_armed <= 1'b0;
            exp_done   <= 1'b0;
        end else begin
            if (out_valid && exp_q.size() == 0) begin
                $display("An output row appeared with no input row pending");
                $display("Test FAILED");
                $fatal(1);
            end else if (out_valid) begin
                exp_row = exp_q.pop_front();
                assert (out_data == exp_row) else begin
                    $display("Fail out_data: got %h expected %h", out_data, exp_row);
                    $display("Test FAILED");
                    $fatal(1);
                end
                rows_checked++;
                if (pass_armed) begin
                    pass_cnt <= pass_cnt + 1;
                    if (pass_cnt + 1 == cfg_rows) begin
                        exp_done   <= 1'b1;
                        pass_armed <= 1'b0;
                    end
                end
            end
            if (in_valid) begin
                exp_q.push_back(pool_ref(in_data, int'(model_win)));
            end
            if (wb_req && wb_we && wb_adr == addr_ctrl) begin
                model_win <= legal_win(wb_dat_w[2:0]);
                if (wb_dat_w[CTRL_START_BIT]) begin
                    pass_armed <= 1'b1;
                    pass_cnt   <= 0;
                    exp_done   <= 1'b0;
                end
            end
            if (wb_req && wb_we && wb_adr == addr_row_count) begin
                cfg_rows <= int'(wb_dat_w[ROW_COUNT_WIDTH-1:0]);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Protocol and timing checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assert property (@(posedge clk) disable iff (rst) wb_req_d == wb_ack) else begin
        $display("Fail wb_ack: got %0h expected %0h", wb_ack, wb_req_d);
        $display("Test FAILED");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (rst) wb_ack_d |-> !wb_ack) else begin
        $display("Fail wb_ack: got %0h expected %0h", wb_ack, 1'b0);
        $display("Test FAILED");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (rst) out_valid == in_valid_hist[2]) else begin
        $display("Fail out_valid: got %0h expected %0h", out_valid, in_valid_hist[2]);
        $display("Test FAILED");
        $fatal(1);
    end

    assert property (@(posedge clk) disable iff (rst) done == exp_done) else begin
        $display("Fail done: got %0h expected %0h", done, exp_done);
        $display("Test FAILED");
        $fatal(1);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus tasks. Each starts and ends just after a rising edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [ROW_W-1:0] got,
                               input logic [ROW_W-1:0] expected);
        assert (got === expected) else begin
            $display("Fail %s: got %0h expected %0h", name, got, expected);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic wb_access(input logic we, input logic [7:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        // The request is new only in its first cycle.
        wb_req   <= 1'b1;
        do begin
            @(posedge clk);
            wb_req <= 1'b0;
            waited++;
        end while (!wb_ack && waited < WB_TIMEOUT);
        if (!wb_ack) begin
            $display("Wishbone access to address %0h was never acknowledged", adr);
            $display("Test FAILED");
            $fatal(1);
        end
        rdata = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] wdata);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdata, unused);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] rdata);
        wb_access(1'b0, adr, 32'h0, rdata);
    endtask

    task automatic send_row(input logic [ROW_W-1:0] data);
        in_valid <= 1'b1;
        in_data  <= data;
        rows_sent++;
        @(posedge clk);
    endtask

    task automatic stop_rows();
        in_valid <= 1'b0;
    endtask

    // Queue is looked at on the falling edge, away from the monitor.
    task automatic wait_drained();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT);
        if (exp_q.size() != 0) begin
            $display("Output rows stopped coming with %0d still expected", exp_q.size());
            $display("Test FAILED");
            $fatal(1);
        end
        @(posedge clk);
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!done && waited < DONE_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!done) begin
            $display("The done flag never rose after the last row of the pass");
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int waited;
        seed         = 59514;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = 8'h0;
        wb_dat_w     = 32'h0;
        wb_req       = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        rows_sent    = 0;
        rows_checked = 0;
        waited       = 0;

        @(posedge clk);
        while (rst && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rst) begin
            $display("Reset was never released");
            $display("Test FAILED");
            $fatal(1);
        end
        check_value("wb_ack", wb_ack, 1'b0);
        check_value("out_valid", out_valid, 1'b0);
        check_value("done", done, 1'b0);
        wb_read(addr_ctrl, rd_data);
        check_value("wb_dat_r", rd_data, 32'h1);

        // Back-to-back rows for each window, with full-scale and truncating rows.
        for (int w = 1; w <= 4; w = w * 2) begin
            wb_write(addr_ctrl, 32'(w));
            for (int r = 0; r < 6; r++) begin
                send_row(random_row());
            end
            send_row('1);
            send_row(ALT_ROW);
            stop_rows();
            wait_drained();
        end

        // Unsupported window code falls back to pass-through.
        wb_write(addr_ctrl, 32'h3);
        wb_read(addr_ctrl, rd_data);
        check_value("wb_dat_r", rd_data, 32'h1);
        for (int r = 0; r < 4; r++) begin
            send_row(random_row());
        end
        stop_rows();
        wait_drained();

        // Window changes while rows keep streaming.
        wb_write(addr_ctrl, 32'h4);
        fork
            begin
                for (int r = 0; r < 8; r++) begin
                    send_row(random_row());
                end
                stop_rows();
            end
            begin
                repeat (3) @(posedge clk);
                wb_write(addr_ctrl, 32'h2);
            end
        join
        wait_drained();

        // Pass of five rows, then extra rows, then a fresh start.
        wb_write(addr_row_count, 32'd5);
        wb_write(addr_ctrl, (32'h1 << CTRL_START_BIT) | 32'h1);
        wb_read(addr_status, rd_data);
        check_value("wb_dat_r", rd_data, 32'h0);
        for (int r = 0; r < 5; r++) begin
            send_row(random_row());
        end
        stop_rows();
        wait_done();
        wb_read(addr_status, rd_data);
        check_value("wb_dat_r", rd_data, 32'h1);
        for (int r = 0; r < 3; r++) begin
            send_row(random_row());
        end
        stop_rows();
        wait_drained();
        wb_read(addr_status, rd_data);
        check_value("wb_dat_r", rd_data, 32'h1);
        wb_write(addr_ctrl, 32'h1 << CTRL_START_BIT);
        wb_read(addr_status, rd_data);
        check_value("wb_dat_r", rd_data, 32'h0);

        if (rows_checked != rows_sent) begin
            $display("Only %0d of %0d rows were checked", rows_checked, rows_sent);
            $display("Test FAILED");
            $fatal(1);
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

// Free-running clock and a reset held for a fixed number of cycles.
module tb_clock #(
    parameter int PERIOD_NS = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: rtl/pool_top.sv
`timescale 1ns/1ps

module pool_top
    import pool_pkg::*;
    import pool_csr_pkg::*;
#(
    parameter int DESIGN_SIZE = DESIGN_SIZE_DEFAULT
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [7:0]                    wb_adr,
    input  logic [31:0]                   wb_dat_w,
    output logic [31:0]                   wb_dat_r,
    output logic                          wb_ack,
    input  logic                          in_valid,
    input  logic [DESIGN_SIZE*DWIDTH-1:0] in_data,
    output logic                          out_valid,
    output logic [DESIGN_SIZE*DWIDTH-1:0] out_data,
    output logic                          done
);

    localparam int LANES = DESIGN_SIZE / LANE_ELEMS;

    csr_addr_e                  csr_adr;
    pool_window_e               window;
    logic [ROW_COUNT_WIDTH-1:0] row_count;
    logic                       start;
    logic                       pass_done;

    pool_row_if #(.DESIGN_SIZE(DESIGN_SIZE)) row_bus ();
    pool_lane_if lane_bus [LANES] ();

    assign csr_adr = csr_addr_e'(wb_adr);

    pool_csr u_csr (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_we,
        .wb_adr    (csr_adr),
        .wb_dat_w, .wb_dat_r, .wb_ack,
        .pass_done, .window, .row_count, .start, .done
    );

    row_dispatch #(.DESIGN_SIZE(DESIGN_SIZE)) u_dispatch (
        .clk, .rst,
        .in_valid, .in_data,
        .window, .row_count, .start,
        .row       (row_bus)
    );

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        pool_lane #(
            .DESIGN_SIZE (DESIGN_SIZE),
            .LANE_INDEX  (l)
        ) u_lane (
            .clk, .rst,
            .row    (row_bus),
            .result (lane_bus[l])
        );
    end

    row_collect #(.DESIGN_SIZE(DESIGN_SIZE)) u_collect (
        .clk, .rst,
        .lanes     (lane_bus),
        .out_valid, .out_data, .pass_done
    );

endmodule

// File: rtl/row_collect.sv
`timescale 1ns/1ps

module row_collect
    import pool_pkg::*;
#(
    parameter int DESIGN_SIZE = DESIGN_SIZE_DEFAULT
) (
    input  logic                          clk,
    input  logic                          rst,
    pool_lane_if.sink                     lanes [DESIGN_SIZE/LANE_ELEMS],
    output logic                          out_valid,
    output logic [DESIGN_SIZE*DWIDTH-1:0] out_data,
    output logic                          pass_done
);

    localparam int LANES = DESIGN_SIZE / LANE_ELEMS;
    localparam int LANE_W = LANE_ELEMS * DWIDTH;

    logic [LANE_W-1:0]             lane_data [LANES];
    logic                          row_valid;
    logic                          row_last;
    pool_window_e                  row_window;
    logic [DESIGN_SIZE*DWIDTH-1:0] packed_row;

    for (genvar l = 0; l < LANES; l++) begin : g_unpack
        assign lane_data[l] = lanes[l].data;
    end

    // All lanes move in lock step, so lane 0 speaks for the row.
    assign row_valid  = lanes[0].valid;
    assign row_last   = lanes[0].last;
    assign row_window = lanes[0].window;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compaction. Lane l lands at element 4l, 2l or l.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        packed_row = '0;
        for (int l = 0; l < LANES; l++) begin
            case (row_window)
                win_2: begin
                    packed_row[l*2*DWIDTH +: 2*DWIDTH] = lane_data[l][2*DWIDTH-1:0];
                end
                win_4: begin
                    packed_row[l*DWIDTH +: DWIDTH] = lane_data[l][DWIDTH-1:0];
                end
                default: begin
                    packed_row[l*LANE_W +: LANE_W] = lane_data[l];
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            pass_done <= 1'b0;
        end else begin
            out_valid <= row_valid;
            pass_done <= row_valid && row_last;
        end
    end

    always_ff @(posedge clk) begin
        if (row_valid) begin
            out_data <= packed_row;
        end
    end

endmodule

// File: rtl/pool_lane.sv
`timescale 1ns/1ps

module pool_lane
    import pool_pkg::*;
#(
    parameter int DESIGN_SIZE = DESIGN_SIZE_DEFAULT,
    parameter int LANE_INDEX = 0
) (
    input  logic       clk,
    input  logic       rst,
    pool_row_if.sink   row,
    pool_lane_if.source result
);

    localparam int BASE = LANE_INDEX * LANE_ELEMS;

    logic [DESIGN_SIZE*DWIDTH-1:0] row_data;
    logic [DWIDTH-1:0]             elem [LANE_ELEMS];
    logic [DWIDTH:0]               sum_lo;
    logic [DWIDTH:0]               sum_hi;
    logic [DWIDTH+1:0]             sum_all;
    logic [LANE_ELEMS*DWIDTH-1:0]  avg;

    assign row_data = row.data;

    for (genvar e = 0; e < LANE_ELEMS; e++) begin : g_elem
        assign elem[e] = row_data[(BASE + e)*DWIDTH +: DWIDTH];
    end

    // Sums are widened so the shift truncates without overflow.
    assign sum_lo  = {1'b0, elem[0]} + {1'b0, elem[1]};
    assign sum_hi  = {1'b0, elem[2]} + {1'b0, elem[3]};
    assign sum_all = {1'b0, sum_lo} + {1'b0, sum_hi};

    always_comb begin
        avg = '0;
        case (row.window)
            win_2: begin
                avg[0*DWIDTH +: DWIDTH] = sum_lo[DWIDTH:1];
                avg[1*DWIDTH +: DWIDTH] = sum_hi[DWIDTH:1];
            end
            win_4:   avg[0*DWIDTH +: DWIDTH] = sum_all[DWIDTH+1:2];
            default: avg = {elem[3], elem[2], elem[1], elem[0]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
            result.last  <= 1'b0;
        end else begin
            result.valid <= row.valid;
            result.last  <= row.valid && row.last;
        end
    end

    always_ff @(posedge clk) begin
        if (row.valid) begin
            result.data   <= avg;
            result.window <= row.window;
        end
    end

endmodule

// File: rtl/row_dispatch.sv
`timescale 1ns/1ps

module row_dispatch
    import pool_pkg::*;
    import pool_csr_pkg::*;
#(
    parameter int DESIGN_SIZE = DESIGN_SIZE_DEFAULT
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic [DESIGN_SIZE*DWIDTH-1:0] in_data,
    input  pool_window_e                  window,
    input  logic [ROW_COUNT_WIDTH-1:0]    row_count,
    input  logic                          start,
    pool_row_if.source                    row
);

    logic [ROW_COUNT_WIDTH-1:0] count;
    logic [ROW_COUNT_WIDTH-1:0] count_base;
    logic [ROW_COUNT_WIDTH-1:0] count_inc;
    logic                       armed;
    logic                       active;
    logic                       hit;

    // A row arriving with the start pulse is the first of the new pass.
    assign count_base = start ? '0 : count;
    assign count_inc  = count_base + 1'b1;
    assign active     = start || armed;

    assign hit = in_valid && active && (row_count != '0) && (count_inc == row_count);

    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            armed     <= 1'b0;
            row.valid <= 1'b0;
            row.last  <= 1'b0;
        end else begin
            row.valid <= in_valid;
            row.last  <= hit;

            if (in_valid && active) begin
                count <= count_inc;
            end else if (start) begin
                count <= '0;
            end

            // Counting stops at the last row until the next start.
            if (hit) begin
                armed <= 1'b0;
            end else if (start) begin
                armed <= 1'b1;
            end
        end
    end

    // Window travels with its row.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            row.data   <= in_data;
            row.window <= window;
        end
    end

endmodule

// File: rtl/pool_csr.sv
`timescale 1ns/1ps

module pool_csr
    import pool_pkg::*;
    import pool_csr_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  csr_addr_e                  wb_adr,
    input  logic [31:0]                wb_dat_w,
    output logic [31:0]                wb_dat_r,
    output logic                       wb_ack,
    input  logic                       pass_done,
    output pool_window_e               window,
    output logic [ROW_COUNT_WIDTH-1:0] row_count,
    output logic                       start,
    output logic                       done
);

    logic                      req;
    logic                      wr_ctrl;
    logic                      wr_start;
    logic [CTRL_WIN_WIDTH-1:0] wr_win;
    logic [31:0]               rd_val;

    // A held request is not seen again while it is being acknowledged.
    assign req = wb_cyc && wb_stb && !wb_ack;

    assign wr_ctrl  = req && wb_we && (wb_adr == addr_ctrl);
    assign wr_start = wr_ctrl && wb_dat_w[CTRL_START_BIT];
    assign wr_win   = wb_dat_w[CTRL_WIN_LSB +: CTRL_WIN_WIDTH];

    always_comb begin
        rd_val = '0;
        case (wb_adr)
            addr_ctrl:      rd_val[CTRL_WIN_LSB +: CTRL_WIN_WIDTH] = window;
            addr_row_count: rd_val[ROW_COUNT_WIDTH-1:0] = row_count;
            addr_status:    rd_val[STATUS_DONE_BIT] = done;
            default:        rd_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            window    <= win_1;
            row_count <= '0;
            start     <= 1'b0;
            done      <= 1'b0;
        end else begin
            wb_ack <= req;
            start  <= wr_start;

            if (wr_ctrl) begin
                // Unsupported window codes fall back to pass-through.
                case (wr_win)
                    3'd2:    window <= win_2;
                    3'd4:    window <= win_4;
                    default: window <= win_1;
                endcase
            end

            if (req && wb_we && (wb_adr == addr_row_count)) begin
                row_count <= wb_dat_w[ROW_COUNT_WIDTH-1:0];
            end

            // Start wins over a pass ending in the same cycle.
            if (wr_start) begin
                done <= 1'b0;
            end else if (pass_done) begin
                done <= 1'b1;
            end
        end
    end

    // Read data is valid on the acknowledge cycle.
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_val;
        end
    end

endmodule

// File: rtl/pool_lane_if.sv
`timescale 1ns/1ps

// Result of one lane; unused elements are zero.
interface pool_lane_if
    import pool_pkg::*;
();

    logic                         valid;
    logic [LANE_ELEMS*DWIDTH-1:0] data;
    pool_window_e                 window;
    logic                         last;

    modport source (
        output valid, data, window, last
    );

    modport sink (
        input valid, data, window, last
    );

endinterface

// File: rtl/pool_row_if.sv
`timescale 1ns/1ps

// One registered input row, broadcast to every lane.
interface pool_row_if
    import pool_pkg::*;
#(
    parameter int DESIGN_SIZE = DESIGN_SIZE_DEFAULT
) ();

    logic                          valid;
    logic [DESIGN_SIZE*DWIDTH-1:0] data;
    pool_window_e                  window;
    logic                          last;

    modport source (
        output valid, data, window, last
    );

    modport sink (
        input valid, data, window, last
    );

endinterface

// File: rtl/pool_csr_pkg.sv
package pool_csr_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register addresses on the Wishbone port.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [7:0] {
        addr_ctrl      = 8'h00,
        addr_row_count = 8'h04,
        addr_status    = 8'h08
    } csr_addr_e;

    // CTRL fields.
    localparam int CTRL_WIN_LSB = 0;
    localparam int CTRL_WIN_WIDTH = 3;
    localparam int CTRL_START_BIT = 8;

    // STATUS fields.
    localparam int STATUS_DONE_BIT = 0;

    // Rows per pass.
    localparam int ROW_COUNT_WIDTH = 16;

endpackage

// File: rtl/pool_pkg.sv
package pool_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath sizes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DWIDTH = 8;
    localparam int DESIGN_SIZE_DEFAULT = 16;

    // One lane covers the widest window.
    localparam int LANE_ELEMS = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pool window, encoded as the number of elements averaged.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        win_1 = 3'd1,
        win_2 = 3'd2,
        win_4 = 3'd4
    } pool_window_e;

endpackage
